/* Makefile */
TOP := tb_fetch_core
OBJ := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

/* filelist.f */
src/fetch_pkg.sv
src/pc_gen.sv
src/line_buffer.sv
src/axi_read_arbiter.sv
src/fetch_core_top.sv
test/fetch_core_assert.sv
test/tb_fetch_core.sv

/* src/axi_read_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_arbiter (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  fetch_pkg::refill_req_t i_refill,
    input  fetch_pkg::dread_req_t  i_dreq,
    output fetch_pkg::axi_ar_t     o_ar,
    input  logic                   i_arready,
    input  fetch_pkg::axi_r_t      i_r,
    output logic                   o_rready,
    output fetch_pkg::axi_r_t      o_ibeat,
    output fetch_pkg::dread_resp_t o_dresp
);

    logic                             ar_valid_q;
    logic [fetch_pkg::ID_W-1:0]       ar_id_q;
    logic [fetch_pkg::ADDR_W-1:0]     ar_addr_q;
    logic [7:0]                       ar_len_q;
    logic                             rd_busy_q;
    logic                             dreq_pend_q;
    logic [fetch_pkg::ADDR_W-1:0]     dreq_addr_q;
    logic                             data_active;
    logic                             ar_load;
    logic                             beat_hs;

    // a data read counts as active from the pulse until its response
    assign data_active = dreq_pend_q ||
                         ((ar_valid_q || rd_busy_q) && (ar_id_q == fetch_pkg::DATA_ID));
    assign ar_load     = !ar_valid_q && !rd_busy_q && (dreq_pend_q || i_refill.valid);
    assign beat_hs     = i_r.valid && rd_busy_q;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            ar_valid_q  <= 1'b0;
            rd_busy_q   <= 1'b0;
            dreq_pend_q <= 1'b0;
        end else begin
            if (ar_load) begin
                ar_valid_q <= 1'b1;
            end else if (ar_valid_q && i_arready) begin
                ar_valid_q <= 1'b0;
                rd_busy_q  <= 1'b1;
            end
            if (beat_hs && i_r.last) begin
                rd_busy_q <= 1'b0;
            end
            if (i_dreq.valid && !data_active) begin
                dreq_pend_q <= 1'b1;
            end else if (ar_load && dreq_pend_q) begin
                dreq_pend_q <= 1'b0;
            end
        end
    end

    // data read goes ahead of a waiting refill
    always_ff @(posedge aclk) begin
        if (i_dreq.valid && !data_active) begin
            dreq_addr_q <= i_dreq.addr;
        end
        if (ar_load) begin
            if (dreq_pend_q) begin
                ar_id_q   <= fetch_pkg::DATA_ID;
                ar_addr_q <= dreq_addr_q;
                ar_len_q  <= fetch_pkg::WORD_LEN;
            end else begin
                ar_id_q   <= fetch_pkg::INSTR_ID;
                ar_addr_q <= i_refill.addr;
                ar_len_q  <= fetch_pkg::LINE_LEN;
            end
        end
    end

    always_comb begin
        o_ar.id    = ar_id_q;
        o_ar.addr  = ar_addr_q;
        o_ar.len   = ar_len_q;
        o_ar.size  = fetch_pkg::BEAT_SIZE;
        o_ar.burst = fetch_pkg::BURST_INCR;
        o_ar.lock  = 2'b00;
        o_ar.cache = 4'b0000;
        o_ar.prot  = 3'b000;
        o_ar.valid = ar_valid_q;
    end

    assign o_rready = rd_busy_q;

    // steer beats by id
    always_comb begin
        o_ibeat       = i_r;
        o_ibeat.valid = beat_hs && (i_r.id == fetch_pkg::INSTR_ID);
    end

    assign o_dresp.valid = beat_hs && i_r.last && (i_r.id == fetch_pkg::DATA_ID);
    assign o_dresp.data  = i_r.data;

endmodule

`default_nettype wire

/* src/fetch_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_core_top (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  fetch_pkg::redirect_t   i_redirect,
    input  logic                   i_fetch_buf_full,
    input  fetch_pkg::dread_req_t  i_dreq,
    input  logic                   i_arready,
    input  fetch_pkg::axi_r_t      i_r,
    output fetch_pkg::axi_ar_t     o_ar,
    output logic                   o_rready,
    output fetch_pkg::fetch_pair_t o_fetch,
    output fetch_pkg::dread_resp_t o_dresp
);

    logic [fetch_pkg::ADDR_W-1:0] pc_q;
    logic                         advance;
    logic                         flush;
    fetch_pkg::refill_req_t       refill;
    fetch_pkg::axi_r_t            ibeat;

    // any redirect kills the pair in flight
    assign flush = i_redirect.wb_valid | i_redirect.ex_valid | i_redirect.dec_valid;

    pc_gen pc_gen_i (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .i_redirect       (i_redirect),
        .i_fetch_buf_full (i_fetch_buf_full),
        .i_advance        (advance),
        .o_pc             (pc_q)
    );

    line_buffer line_buffer_i (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .i_pc             (pc_q),
        .i_fetch_buf_full (i_fetch_buf_full),
        .i_flush          (flush),
        .i_beat           (ibeat),
        .o_advance        (advance),
        .o_fetch          (o_fetch),
        .o_refill         (refill)
    );

    axi_read_arbiter axi_read_arbiter_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .i_refill  (refill),
        .i_dreq    (i_dreq),
        .o_ar      (o_ar),
        .i_arready (i_arready),
        .i_r       (i_r),
        .o_rready  (o_rready),
        .o_ibeat   (ibeat),
        .o_dresp   (o_dresp)
    );

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    localparam int ADDR_W        = 32;
    localparam int DATA_W        = 32;
    localparam int ID_W          = 4;
    localparam int LINE_WORDS    = 16;
    localparam int LINE_OFFSET_W = 6;
    localparam int PAIR_BYTES    = 8;

    // AXI read attributes
    localparam logic [ID_W-1:0]   INSTR_ID   = 4'd0;
    localparam logic [ID_W-1:0]   DATA_ID    = 4'd1;
    localparam logic [7:0]        LINE_LEN   = 8'd15;
    localparam logic [7:0]        WORD_LEN   = 8'd0;
    localparam logic [2:0]        BEAT_SIZE  = 3'd2;
    localparam logic [1:0]        BURST_INCR = 2'd1;
    localparam logic [ADDR_W-1:0] RESET_PC   = 32'h0000_0000;

    typedef struct packed {
        logic              wb_valid;
        logic [ADDR_W-1:0] wb_target;
        logic              ex_valid;
        logic [ADDR_W-1:0] ex_target;
        logic              dec_valid;
        logic [ADDR_W-1:0] dec_target;
    } redirect_t;

    // instr0 sits at the lower address
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        logic [DATA_W-1:0] instr0;
        logic [DATA_W-1:0] instr1;
    } fetch_pair_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } refill_req_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
    } dread_req_t;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
    } dread_resp_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
        logic [1:0]        lock;
        logic [3:0]        cache;
        logic [2:0]        prot;
        logic              valid;
    } axi_ar_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
        logic              valid;
    } axi_r_t;

endpackage

`default_nettype wire

/* src/line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic [fetch_pkg::ADDR_W-1:0] i_pc,
    input  logic                         i_fetch_buf_full,
    input  logic                         i_flush,
    input  fetch_pkg::axi_r_t            i_beat,
    output logic                         o_advance,
    output fetch_pkg::fetch_pair_t       o_fetch,
    output fetch_pkg::refill_req_t       o_refill
);

    logic [fetch_pkg::DATA_W-1:0] line_mem [fetch_pkg::LINE_WORDS];

    logic [fetch_pkg::ADDR_W-fetch_pkg::LINE_OFFSET_W-1:0] tag_q;
    logic [fetch_pkg::ADDR_W-fetch_pkg::LINE_OFFSET_W-1:0] refill_tag_q;
    logic [fetch_pkg::ADDR_W-fetch_pkg::LINE_OFFSET_W-1:0] pc_tag;
    logic                                                  tag_valid_q;
    logic                                                  refill_q;
    logic [$clog2(fetch_pkg::LINE_WORDS)-1:0]              beat_idx_q;
    logic [$clog2(fetch_pkg::LINE_WORDS)-2:0]              pair_idx;
    logic                                                  hit;
    logic                                                  refill_start;
    logic                                                  beat_wr;

    logic                         fetch_valid_q;
    logic [fetch_pkg::ADDR_W-1:0] fetch_pc_q;
    logic [fetch_pkg::DATA_W-1:0] fetch_i0_q;
    logic [fetch_pkg::DATA_W-1:0] fetch_i1_q;

    assign pc_tag   = i_pc[fetch_pkg::ADDR_W-1:fetch_pkg::LINE_OFFSET_W];
    assign pair_idx = i_pc[fetch_pkg::LINE_OFFSET_W-1:3];
    assign hit      = tag_valid_q && (tag_q == pc_tag);

    // no point fetching a line for a pc that is being replaced
    assign refill_start = !hit && !refill_q && !i_flush;
    assign beat_wr      = refill_q && i_beat.valid && (i_beat.id == fetch_pkg::INSTR_ID);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            tag_valid_q <= 1'b0;
            refill_q    <= 1'b0;
            beat_idx_q  <= '0;
        end else if (refill_start) begin
            tag_valid_q <= 1'b0;
            refill_q    <= 1'b1;
            beat_idx_q  <= '0;
        end else if (beat_wr) begin
            beat_idx_q <= beat_idx_q + 1'b1;
            if (i_beat.last) begin
                tag_valid_q <= 1'b1;
                refill_q    <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (refill_start) begin
            refill_tag_q <= pc_tag;
        end
        if (beat_wr && i_beat.last) begin
            tag_q <= refill_tag_q;
        end
        if (beat_wr) begin
            line_mem[beat_idx_q] <= i_beat.data;
        end
    end

    // pair out, registered one cycle after the hit
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            fetch_valid_q <= 1'b0;
        end else begin
            fetch_valid_q <= hit && !i_fetch_buf_full && !i_flush;
        end
    end

    always_ff @(posedge aclk) begin
        fetch_pc_q <= i_pc;
        fetch_i0_q <= line_mem[{pair_idx, 1'b0}];
        fetch_i1_q <= line_mem[{pair_idx, 1'b1}];
    end

    assign o_advance       = hit;
    assign o_fetch.valid   = fetch_valid_q;
    assign o_fetch.pc      = fetch_pc_q;
    assign o_fetch.instr0  = fetch_i0_q;
    assign o_fetch.instr1  = fetch_i1_q;
    assign o_refill.valid  = refill_q;
    assign o_refill.addr   = {refill_tag_q, {fetch_pkg::LINE_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

/* src/pc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  fetch_pkg::redirect_t         i_redirect,
    input  logic                         i_fetch_buf_full,
    input  logic                         i_advance,
    output logic [fetch_pkg::ADDR_W-1:0] o_pc
);

    logic [fetch_pkg::ADDR_W-1:0] pc_q;
    logic [fetch_pkg::ADDR_W-1:0] pc_next;
    logic                         pc_load;

    // oldest stage has the final word on the pc
    always_comb begin
        pc_load = 1'b1;
        pc_next = pc_q + fetch_pkg::ADDR_W'(fetch_pkg::PAIR_BYTES);
        if (i_redirect.wb_valid) begin
            pc_next = i_redirect.wb_target;
        end else if (i_redirect.ex_valid) begin
            pc_next = i_redirect.ex_target;
        end else if (i_redirect.dec_valid) begin
            pc_next = i_redirect.dec_target;
        end else if (!i_advance || i_fetch_buf_full) begin
            // miss or full buffer, hold
            pc_load = 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            pc_q <= fetch_pkg::RESET_PC;
        end else if (pc_load) begin
            pc_q <= pc_next;
        end
    end

    assign o_pc = pc_q;

endmodule

`default_nettype wire

/* test/fetch_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_core_assert (
    input logic                   aclk,
    input logic                   aresetn,
    input fetch_pkg::axi_ar_t     i_ar,
    input logic                   i_arready,
    input fetch_pkg::fetch_pair_t i_fetch
);

    // AR held with stable fields until accepted
    ar_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        (i_ar.valid && !i_arready) |=> (i_ar.valid && $stable(i_ar)))
        else $error("AR dropped or changed before acceptance");

    ar_len: assert property (@(posedge aclk) disable iff (!aresetn)
        i_ar.valid |-> ((i_ar.id == fetch_pkg::INSTR_ID && i_ar.len == fetch_pkg::LINE_LEN) ||
                        (i_ar.id == fetch_pkg::DATA_ID && i_ar.len == fetch_pkg::WORD_LEN)))
        else $error("AR length does not match its id");

    fetch_in_reset: assert property (@(posedge aclk) !aresetn |=> !i_fetch.valid)
        else $error("fetch pair valid during reset");

endmodule

bind fetch_core_top fetch_core_assert fetch_core_assert_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .i_ar      (o_ar),
    .i_arready (i_arready),
    .i_fetch   (o_fetch)
);

`default_nettype wire

/* test/tb_fetch_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_core;

    localparam logic [31:0] PATTERN = 32'hA5A5_0000;
    localparam int          TIMEOUT = 2000;
    localparam logic [1:0]  K_RUN   = 2'd0;
    localparam logic [1:0]  K_REDIR = 2'd1;
    localparam logic [1:0]  K_HOLD  = 2'd2;
    localparam logic [1:0]  K_DREAD = 2'd3;
    localparam int          NSTEPS  = 9;

    // rv bits are wb, ex, dec
    typedef struct packed {
        logic [1:0]  kind;
        logic [2:0]  rv;
        logic [31:0] wb_t;
        logic [31:0] ex_t;
        logic [31:0] dec_t;
        logic [15:0] count;
        logic [31:0] addr;
        logic [31:0] exp_val;
        logic        chk_ar;
        logic [3:0]  ar_id;
        logic [31:0] ar_addr;
    } step_t;

    logic                   aclk;
    logic                   aresetn;
    fetch_pkg::redirect_t   i_redirect;
    logic                   i_fetch_buf_full;
    fetch_pkg::dread_req_t  i_dreq;
    logic                   i_arready;
    fetch_pkg::axi_r_t      i_r;
    fetch_pkg::axi_ar_t     o_ar;
    logic                   o_rready;
    fetch_pkg::fetch_pair_t o_fetch;
    fetch_pkg::dread_resp_t o_dresp;

    step_t              steps [NSTEPS];
    logic [31:0]        pair_q [$];
    fetch_pkg::axi_ar_t ar_log [$];
    fetch_pkg::axi_ar_t burst;
    logic               burst_on;
    int                 beat_k;
    int                 line_fills;
    int                 dresp_cnt;
    logic [31:0]        dresp_data;

    fetch_core_top dut_i (
        .aclk             (aclk),
        .aresetn          (aresetn),
        .i_redirect       (i_redirect),
        .i_fetch_buf_full (i_fetch_buf_full),
        .i_dreq           (i_dreq),
        .i_arready        (i_arready),
        .i_r              (i_r),
        .o_ar             (o_ar),
        .o_rready         (o_rready),
        .o_fetch          (o_fetch),
        .o_dresp          (o_dresp)
    );

    initial aclk = 1'b0;
    always #5 aclk = ~aclk;

    // memory model, one read at a time with random gaps
    always @(negedge aclk) begin
        if (!aresetn) begin
            i_arready = 1'b0;
            i_r       = '0;
            burst_on  = 1'b0;
            beat_k    = 0;
        end else begin
            if (i_r.valid) begin
                if (i_r.last) begin
                    burst_on = 1'b0;
                    if (burst.id == fetch_pkg::INSTR_ID) begin
                        line_fills++;
                    end
                end else begin
                    beat_k++;
                end
            end
            i_r       = '0;
            i_arready = 1'b0;
            if (o_ar.valid && !burst_on && ($urandom % 3 != 0)) begin
                i_arready = 1'b1;
                burst     = o_ar;
                burst_on  = 1'b1;
                beat_k    = 0;
                ar_log.push_back(o_ar);
            end else if (burst_on && o_rready && ($urandom % 4 != 0)) begin
                i_r.valid = 1'b1;
                i_r.id    = burst.id;
                i_r.data  = (burst.addr + 32'(4 * beat_k)) ^ PATTERN;
                i_r.last  = (beat_k == int'(burst.len));
            end
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout at %0t while waiting for %s", $time, what);
        $display("Simulation failed");
        $fatal(1, "timeout");
    endtask

    // one cycle; o_dresp follows the R beat, so it is taken at the rising edge
    task automatic tick();
        @(posedge aclk);
        if (o_dresp.valid) begin
            dresp_cnt++;
            dresp_data = o_dresp.data;
        end
        @(negedge aclk);
        if (o_fetch.valid) begin
            check_val("o_fetch.instr0", o_fetch.instr0, o_fetch.pc ^ PATTERN);
            check_val("o_fetch.instr1", o_fetch.instr1, (o_fetch.pc + 32'd4) ^ PATTERN);
            assert (line_fills > 0) else begin
                $display("Pair delivered at %0t before any line refill finished", $time);
                $display("Simulation failed");
                $fatal(1, "early pair");
            end
            pair_q.push_back(o_fetch.pc);
        end
    endtask

    task automatic wait_pair(output logic [31:0] pc);
        int n;
        n = 0;
        while (pair_q.size() == 0) begin
            if (n == TIMEOUT) begin
                timeout_fail("a fetched pair");
            end
            tick();
            n++;
        end
        pc = pair_q.pop_front();
    endtask

    task automatic check_ar_issued(input int start, input logic [3:0] id, input logic [31:0] addr);
        int idx;
        idx = -1;
        for (int i = start; i < ar_log.size(); i++) begin
            if (idx < 0 && ar_log[i].id == id && ar_log[i].addr == addr) begin
                idx = i;
            end
        end
        assert (idx >= 0) else begin
            $display("No AR with id %0d and address %h was issued by %0t", id, addr, $time);
            $display("Simulation failed");
            $fatal(1, "missing AR");
        end
        check_val("o_ar.len", 32'(ar_log[idx].len), (id == 4'd0) ? 32'd15 : 32'd0);
        check_val("o_ar.size", 32'(ar_log[idx].size), 32'd2);
        check_val("o_ar.burst", 32'(ar_log[idx].burst), 32'd1);
        check_val("o_ar.lock", 32'(ar_log[idx].lock), 32'd0);
        check_val("o_ar.cache", 32'(ar_log[idx].cache), 32'd0);
        check_val("o_ar.prot", 32'(ar_log[idx].prot), 32'd0);
    endtask

    task automatic drive_redirect(input step_t s);
        i_redirect.wb_valid   = s.rv[2];
        i_redirect.wb_target  = s.wb_t;
        i_redirect.ex_valid   = s.rv[1];
        i_redirect.ex_target  = s.ex_t;
        i_redirect.dec_valid  = s.rv[0];
        i_redirect.dec_target = s.dec_t;
    endtask

    task automatic run_step(input step_t s);
        logic [31:0] pc;
        int          start;
        int          n;
        int          n0;
        start = ar_log.size();
        case (s.kind)
            K_RUN: begin
                for (int i = 0; i < int'(s.count); i++) begin
                    wait_pair(pc);
                    check_val("o_fetch.pc", pc, s.exp_val + 32'(8 * i));
                end
            end
            K_REDIR: begin
                drive_redirect(s);
                pair_q.delete();
                tick();
                i_redirect = '0;
                wait_pair(pc);
                check_val("o_fetch.pc", pc, s.exp_val);
            end
            K_HOLD: begin
                i_fetch_buf_full = 1'b1;
                n0 = pair_q.size();
                repeat (int'(s.count)) tick();
                check_val("pairs during hold", 32'(pair_q.size()), 32'(n0));
                i_fetch_buf_full = 1'b0;
                wait_pair(pc);
                check_val("o_fetch.pc", pc, s.exp_val);
            end
            default: begin
                // sync to an idle bus right after a hit
                n = 0;
                do begin
                    if (n == TIMEOUT) begin
                        timeout_fail("an idle read channel");
                    end
                    tick();
                    n++;
                end while (!(o_fetch.valid && !o_ar.valid && !o_rready));
                start = ar_log.size();
                n0 = dresp_cnt;
                if (s.rv != 3'b000) begin
                    // the new line's refill and the data read then meet at AR
                    drive_redirect(s);
                    pair_q.delete();
                    tick();
                    i_redirect = '0;
                end
                i_dreq.valid = 1'b1;
                i_dreq.addr  = s.addr;
                tick();
                i_dreq = '0;
                n = 0;
                while (dresp_cnt == n0) begin
                    if (n == TIMEOUT) begin
                        timeout_fail("the data read response");
                    end
                    tick();
                    n++;
                end
                check_val("o_dresp.data", dresp_data, s.exp_val);
                check_val("first AR id", 32'(ar_log[start].id), 32'(fetch_pkg::DATA_ID));
            end
        endcase
        if (s.chk_ar) begin
            check_ar_issued(start, s.ar_id, s.ar_addr);
        end
    endtask

    initial begin
        aresetn          = 1'b0;
        i_redirect       = '0;
        i_fetch_buf_full = 1'b0;
        i_dreq           = '0;
        i_arready        = 1'b0;
        i_r              = '0;
        line_fills       = 0;
        dresp_cnt        = 0;
        dresp_data       = '0;
        void'($urandom(87203));

        steps[0] = '{K_RUN, 3'b000, 0, 0, 0, 16'd8, 0, 32'h0, 1'b1, 4'd0, 32'h0};
        steps[1] = '{K_RUN, 3'b000, 0, 0, 0, 16'd2, 0, 32'h40, 1'b1, 4'd0, 32'h40};
        steps[2] = '{K_HOLD, 3'b000, 0, 0, 0, 16'd6, 0, 32'h50, 1'b0, 4'd0, 32'h0};
        steps[3] = '{K_REDIR, 3'b111, 32'h200, 32'h300, 32'h400, 16'd0, 0, 32'h200,
                     1'b1, 4'd0, 32'h200};
        steps[4] = '{K_REDIR, 3'b011, 0, 32'h240, 32'h500, 16'd0, 0, 32'h240,
                     1'b1, 4'd0, 32'h240};
        steps[5] = '{K_RUN, 3'b000, 0, 0, 0, 16'd3, 0, 32'h248, 1'b0, 4'd0, 32'h0};
        steps[6] = '{K_DREAD, 3'b000, 0, 0, 0, 16'd0, 32'h1234, 32'h1234 ^ PATTERN,
                     1'b1, 4'd1, 32'h1234};
        steps[7] = '{K_DREAD, 3'b001, 0, 0, 32'h600, 16'd0, 32'h2468, 32'h2468 ^ PATTERN,
                     1'b1, 4'd1, 32'h2468};
        steps[8] = '{K_RUN, 3'b000, 0, 0, 0, 16'd2, 0, 32'h600, 1'b1, 4'd0, 32'h600};

        repeat (8) tick();
        aresetn = 1'b1;
        for (int i = 0; i < NSTEPS; i++) begin
            run_step(steps[i]);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire
